// File: uart_line_pkg.sv
package uart_line_pkg;

   // Frame format fields, latched by the serializer per byte
   typedef struct packed {
      logic parity_en;   // Add a parity bit after data
      logic parity_odd;  // Odd parity when set, even otherwise
      logic two_stop;    // Two stop bits when set
   } line_ctrl_t;

   // FIFO fill flags, all derived from the word count
   typedef struct packed {
      logic full;          // Count equals depth
      logic almost_full;   // Count above upper threshold
      logic almost_empty;  // Count below lower threshold
      logic empty;         // No words stored
   } fifo_status_t;

endpackage

// File: uart_reg_pkg.sv
package uart_reg_pkg;

   // Register map of the transmit block
   typedef enum logic [1:0] {
      ADDR_DIV  = 2'd0,  // Bit period in clock cycles
      ADDR_LINE = 2'd1,  // Line control fields
      ADDR_EN   = 2'd2   // Transmit enable in bit 0
   } reg_addr_e;

   // Line control padded out to a full config word
   typedef struct packed {
      logic [12:0]              pad;
      uart_line_pkg::line_ctrl_t line;
   } cfg_line_t;

   // One config word, read as divisor or as line control
   typedef union packed {
      logic [15:0] div;  // ADDR_DIV and ADDR_EN view
      cfg_line_t   ln;   // ADDR_LINE view
   } cfg_word_u;

   // Host config write, lands when en is high at a clock edge
   typedef struct packed {
      logic      en;
      reg_addr_e addr;
      cfg_word_u data;
   } cfg_wr_t;

endpackage

// File: tx_fifo.sv
`timescale 1ns/100ps

module tx_fifo #(
   parameter int DATA_W = 8,  // Word width
   parameter int DEPTH  = 8,  // Number of words, power of two
   parameter int UPP_TH = 4,  // Almost-full above this count
   parameter int LOW_TH = 2   // Almost-empty below this count
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        wr_en,
   input  logic [DATA_W-1:0]           wr_data,
   input  logic                        rd_en,
   output logic [DATA_W-1:0]           rd_data,
   output uart_line_pkg::fifo_status_t status
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = PTR_W + 1;

   logic [DATA_W-1:0] mem [DEPTH];  // Storage array
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;        // One bit wider to reach DEPTH
   logic              wr_ok;
   logic              rd_ok;

   assign wr_ok = wr_en & ~status.full;   // Pushes into a full FIFO are lost
   assign rd_ok = rd_en & ~status.empty;

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) begin
            if (wr_ptr == PTR_W'(DEPTH - 1)) begin
               wr_ptr <= '0;   // Wrap
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (rd_ok) begin
            if (rd_ptr == PTR_W'(DEPTH - 1)) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         if (wr_ok && !rd_ok) begin
            count <= count + 1'b1;
         end else if (!wr_ok && rd_ok) begin
            count <= count - 1'b1;
         end
      end
   end

   assign status.full         = (count == CNT_W'(DEPTH));
   assign status.empty        = (count == '0);
   assign status.almost_full  = (count > CNT_W'(UPP_TH));
   assign status.almost_empty = (count < CNT_W'(LOW_TH));

   assign rd_data = mem[rd_ptr];  // Head word, valid while not empty

   a_count_bound: assert property (@(posedge clk) disable iff (rst)
      count <= CNT_W'(DEPTH));

   // The reader must only ask for a word that is there
   a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
      rd_en |-> !status.empty);

endmodule

// File: uart_tx_regs.sv
`timescale 1ns/100ps

module uart_tx_regs #(
   parameter int DIV_RESET = 4  // Divisor after reset
) (
   input  logic                      clk,
   input  logic                      rst,
   input  uart_reg_pkg::cfg_wr_t     cfg,
   output logic [15:0]               divisor,
   output uart_line_pkg::line_ctrl_t line,
   output logic                      tx_en
);

   import uart_reg_pkg::*;

   always_ff @(posedge clk) begin
      if (rst) begin
         divisor <= 16'(DIV_RESET);
         line    <= '0;
         tx_en   <= 1'b0;
      end else if (cfg.en) begin
         case (cfg.addr)
            ADDR_DIV: begin
               if (cfg.data.div != '0) begin
                  divisor <= cfg.data.div;  // Zero would stall the bit timer
               end
            end
            ADDR_LINE: line  <= cfg.data.ln.line;
            ADDR_EN:   tx_en <= cfg.data.div[0];
            default: ;  // Unmapped address
         endcase
      end
   end

   a_div_nonzero: assert property (@(posedge clk) disable iff (rst)
      divisor != '0);

endmodule

// File: uart_tx_serializer.sv
`timescale 1ns/100ps

module uart_tx_serializer (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [15:0]               divisor,
   input  uart_line_pkg::line_ctrl_t line,
   input  logic                      tx_en,
   input  logic                      fifo_empty,
   input  logic [7:0]                fifo_data,
   output logic                      pop,
   output logic                      txd,
   output logic                      busy
);

   import uart_line_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_START,
      S_DATA,
      S_PARITY,
      S_STOP
   } state_e;

   state_e     state;
   logic [15:0] cnt;       // Cycles left in the current bit
   logic [2:0]  bit_idx;   // Data bit index, stop bit index in S_STOP
   logic [7:0]  shift;     // Remaining data bits, LSB goes next
   logic        par;       // Running parity of sent data bits
   logic [15:0] div_q;     // Divisor held for the whole frame
   line_ctrl_t  line_q;    // Line fields held for the whole frame
   logic        bit_done;

   assign pop      = (state == S_IDLE) & tx_en & ~fifo_empty;
   assign busy     = (state != S_IDLE);
   assign bit_done = (cnt == '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
         txd   <= 1'b1;  // Line idles high
      end else begin
         case (state)
            S_IDLE: begin
               if (pop) begin
                  txd   <= 1'b0;  // Start bit
                  state <= S_START;
               end
            end
            S_START: begin
               if (bit_done) begin
                  txd   <= shift[0];
                  state <= S_DATA;
               end
            end
            S_DATA: begin
               if (bit_done) begin
                  if (bit_idx != 3'd7) begin
                     txd <= shift[0];
                  end else if (line_q.parity_en) begin
                     txd   <= par;
                     state <= S_PARITY;
                  end else begin
                     txd   <= 1'b1;
                     state <= S_STOP;
                  end
               end
            end
            S_PARITY: begin
               if (bit_done) begin
                  txd   <= 1'b1;
                  state <= S_STOP;
               end
            end
            S_STOP: begin
               if (bit_done && !(line_q.two_stop && bit_idx == 3'd0)) begin
                  state <= S_IDLE;  // txd already high
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // Datapath registers, loaded at pop and advanced at bit ends
   always_ff @(posedge clk) begin
      if (pop) begin
         shift  <= fifo_data;
         div_q  <= divisor;
         line_q <= line;
         par    <= line.parity_odd;  // Odd parity starts inverted
         cnt    <= divisor - 1'b1;
      end else if (state != S_IDLE) begin
         if (bit_done) begin
            cnt <= div_q - 1'b1;
            case (state)
               S_START: begin
                  par     <= par ^ shift[0];
                  shift   <= shift >> 1;
                  bit_idx <= '0;
               end
               S_DATA: begin
                  if (bit_idx != 3'd7) begin
                     par     <= par ^ shift[0];
                     shift   <= shift >> 1;
                     bit_idx <= bit_idx + 1'b1;
                  end else begin
                     bit_idx <= '0;  // Reused to count stop bits
                  end
               end
               S_PARITY: bit_idx <= '0;
               S_STOP:   bit_idx <= bit_idx + 1'b1;
               default: ;
            endcase
         end else begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   // A pop starts a frame only from idle with data present
   a_pop_legal: assert property (@(posedge clk) disable iff (rst)
      pop |-> (!busy && !fifo_empty) ##1 busy);

endmodule

// File: uart_tx_top.sv
`timescale 1ns/100ps

module uart_tx_top #(
   parameter int DATA_W    = 8,  // FIFO word width
   parameter int DEPTH     = 8,  // FIFO depth
   parameter int UPP_TH    = 4,  // Almost-full threshold
   parameter int LOW_TH    = 2,  // Almost-empty threshold
   parameter int DIV_RESET = 4   // Bit period after reset
) (
   input  logic                        clk,
   input  logic                        rst,
   input  uart_reg_pkg::cfg_wr_t       cfg,
   input  logic                        push,
   input  logic [DATA_W-1:0]           push_data,
   output logic                        txd,
   output logic                        busy,
   output uart_line_pkg::fifo_status_t status
);

   import uart_line_pkg::*;

   logic [15:0]       divisor;
   line_ctrl_t        line;
   logic              tx_en;
   logic              pop;
   logic [DATA_W-1:0] fifo_rd_data;

   uart_tx_regs #(
      .DIV_RESET (DIV_RESET)
   ) i_regs (
      .clk     (clk),
      .rst     (rst),
      .cfg     (cfg),
      .divisor (divisor),
      .line    (line),
      .tx_en   (tx_en)
   );

   tx_fifo #(
      .DATA_W (DATA_W),
      .DEPTH  (DEPTH),
      .UPP_TH (UPP_TH),
      .LOW_TH (LOW_TH)
   ) i_fifo (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (push),
      .wr_data (push_data),
      .rd_en   (pop),
      .rd_data (fifo_rd_data),
      .status  (status)
   );

   uart_tx_serializer i_ser (
      .clk        (clk),
      .rst        (rst),
      .divisor    (divisor),
      .line       (line),
      .tx_en      (tx_en),
      .fifo_empty (status.empty),
      .fifo_data  (fifo_rd_data),
      .pop        (pop),
      .txd        (txd),
      .busy       (busy)
   );

endmodule

// File: tb_uart_tx.sv
`timescale 1ns/100ps

module tb_uart_tx;

   import uart_reg_pkg::*;
   import uart_line_pkg::*;

   localparam int WAIT_LIMIT = 2000;  // Cycles any single wait may take

   // One frame as seen on txd
   typedef struct packed {
      logic [15:0] len;   // Bit periods with busy high
      logic        start;
      logic [7:0]  data;
      logic        par;
      logic [1:0]  stop;
   } frame_t;

   logic         clk = 1'b0;
   logic         rst;
   cfg_wr_t      cfg;
   logic         push;
   logic [7:0]   push_data;
   logic         txd;
   logic         busy;
   fifo_status_t status;

   logic [15:0]  div_sh = 16'd4;  // Settings the DUT should hold
   line_ctrl_t   line_sh = '0;
   logic         en_sh = 1'b0;
   frame_t       rx_q[$];         // Frames decoded from txd
   int           errors = 0;
   int           timeouts = 0;

   always #50 clk = ~clk;

   uart_tx_top #(
      .DATA_W    (8),
      .DEPTH     (8),
      .UPP_TH    (4),
      .LOW_TH    (2),
      .DIV_RESET (4)
   ) i_dut (
      .clk       (clk),
      .rst       (rst),
      .cfg       (cfg),
      .push      (push),
      .push_data (push_data),
      .txd       (txd),
      .busy      (busy),
      .status    (status)
   );

   task automatic check_val(input string name, input logic [15:0] exp,
                            input logic [15:0] act);
      assert (exp === act) else begin
         errors++;
         $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
      end
   endtask

   task automatic write_cfg(input logic [1:0] addr, input logic [15:0] data);
      @(posedge clk);
      cfg.en       <= 1'b1;
      cfg.addr     <= reg_addr_e'(addr);
      cfg.data.div <= data;
      @(posedge clk);
      cfg.en <= 1'b0;  // Write lands at this edge
      if (addr == ADDR_DIV && data != '0)
         div_sh = data;  // Zero divisor is ignored
      if (addr == ADDR_LINE)
         line_sh = data[2:0];
      if (addr == ADDR_EN)
         en_sh = data[0];
   endtask

   task automatic push_byte(input logic [7:0] data);
      int gap;
      @(posedge clk);
      push      <= 1'b1;
      push_data <= data;
      @(posedge clk);
      push <= 1'b0;
      if (en_sh) begin
         gap = $urandom % 4;  // Spread pushes while sending
         repeat (gap) @(posedge clk);
      end
   endtask

   task automatic check_status(input logic [3:0] exp);
      int t;
      t = 0;
      @(negedge clk);
      while (busy && t < WAIT_LIMIT) begin
         @(negedge clk);
         t++;
      end
      if (busy) begin
         timeouts++;
         $display("Timeout: busy never fell before the status check");
      end else begin
         check_val("status", exp, status);
      end
   endtask

   task automatic expect_frame(input logic [7:0] data, input logic pe, input logic po,
                               input logic ts);
      frame_t rec;
      int     t;
      t = 0;
      while (rx_q.size() == 0 && t < WAIT_LIMIT) begin
         @(negedge clk);
         t++;
      end
      if (rx_q.size() == 0) begin
         timeouts++;
         $display("Timeout: no frame appeared on txd for byte %h", data);
      end else begin
         rec = rx_q.pop_front();
         check_val("txd frame length", 10 + pe + ts, rec.len);
         check_val("txd start bit", 0, rec.start);
         check_val("txd data", data, rec.data);
         if (pe)
            check_val("txd parity bit", ^data ^ po, rec.par);  // Odd flips even parity
         check_val("txd stop bits", 2'b11, rec.stop);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         if (!en_sh) begin
            check_val("txd", 1, txd);  // No frame may start while disabled
            check_val("busy", 0, busy);
         end
      end
   endtask

   task automatic decode_frame();
      int          t;
      int          k;
      int          c;
      int          nbits;
      int          stop_pos;
      int          busy_cyc;
      logic [15:0] div;
      line_ctrl_t  ln;
      logic [11:0] bits;
      logic        bit_first;
      logic        stable;
      frame_t      rec;
      t = 0;
      @(negedge clk);
      while (txd !== 1'b0 && t < WAIT_LIMIT) begin
         @(negedge clk);
         t++;
      end
      if (txd === 1'b0) begin
         div      = div_sh;
         ln       = line_sh;
         nbits    = 10 + ln.parity_en + ln.two_stop;
         stable   = 1'b1;
         busy_cyc = 0;
         for (k = 0; k < nbits; k++) begin
            for (c = 0; c < div; c++) begin
               if (k != 0 || c != 0)
                  @(negedge clk);
               if (c == 0)
                  bit_first = txd;
               if (txd !== bit_first)
                  stable = 1'b0;
               if (c == div / 2)
                  bits[k] = txd;  // Mid-bit sample
               if (busy === 1'b1)
                  busy_cyc++;
            end
         end
         t = 0;
         @(negedge clk);
         while (busy === 1'b1 && t < WAIT_LIMIT) begin
            busy_cyc++;  // Frame runs past its expected end
            @(negedge clk);
            t++;
         end
         if (busy === 1'b1) begin
            timeouts++;
            $display("Timeout: busy stayed high after a frame on txd");
         end
         assert (stable) else begin
            errors++;
            $display("txd changed inside a bit period in the frame ending at %0t", $time);
         end
         stop_pos   = 9 + ln.parity_en;
         rec.len    = 16'(busy_cyc / div);
         rec.start  = bits[0];
         rec.data   = bits[8:1];
         rec.par    = bits[9];
         rec.stop   = {ln.two_stop ? bits[stop_pos + 1] : 1'b1, bits[stop_pos]};
         rx_q.push_back(rec);
      end
   endtask

   initial begin
      repeat (4) @(posedge clk);
      forever decode_frame();
   end

   initial begin
      int               fd;
      int               code;
      logic [7:0]       cmd;
      logic [15:0]      a;
      logic [15:0]      b;
      logic [15:0]      c;
      logic [15:0]      d;
      logic [8*100-1:0] skip;
      logic             done;
      rst       <= 1'b1;
      cfg       <= '0;
      push      <= 1'b0;
      push_data <= '0;
      void'($urandom(35));
      fd = $fopen("uart_tx_vectors.txt", "r");
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_val("txd", 1, txd);
      check_val("busy", 0, busy);
      done = (fd == 0);
      if (fd == 0) begin
         errors++;
         $display("Cannot open uart_tx_vectors.txt");
      end
      while (!done && timeouts == 0) begin
         code = $fscanf(fd, " %c", cmd);
         if (code != 1) begin
            errors++;
            $display("Vectors file ended without an X command");
            done = 1'b1;
         end else begin
            case (cmd)
               "#": code = $fgets(skip, fd);
               "C": begin
                  code = $fscanf(fd, "%h %h", a, d);
                  write_cfg(a[1:0], d);
               end
               "P": begin
                  code = $fscanf(fd, "%h", d);
                  push_byte(d[7:0]);
               end
               "S": begin
                  code = $fscanf(fd, "%h", d);
                  check_status(d[3:0]);
               end
               "E": begin
                  code = $fscanf(fd, "%h %h %h %h", d, a, b, c);
                  expect_frame(d[7:0], a[0], b[0], c[0]);
               end
               "W": begin
                  code = $fscanf(fd, "%h", d);
                  idle_cycles(int'(d));
               end
               "X": done = 1'b1;
               default: begin
                  errors++;
                  $display("Unknown command in vectors file: %c", cmd);
                  done = 1'b1;
               end
            endcase
         end
      end
      assert (rx_q.size() == 0) else begin
         errors++;
         $display("Frames on txd that no vector expected: %0d", rx_q.size());
      end
      if (fd != 0)
         $fclose(fd);
      $display("Error count: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: uart_tx_vectors.txt
# C addr data | P byte | S status {full,afull,aempty,empty} | E byte par_en par_odd two_stop
# W cycles | X end. Fields are hex, one line may hold several commands of one step.
S 3
P 3c S 2
P a5 S 0
P 01 S 0
P 80 S 0
P ff S 4
P 00 S 4
P 5a S 4
P 7e S c
P e7 S c
P c3 S c
C 2 0001
E 3c 0 0 0 E a5 0 0 0
E 01 0 0 0 E 80 0 0 0
E ff 0 0 0 E 00 0 0 0
E 5a 0 0 0 E 7e 0 0 0
S 3
C 0 0006 P 96 P 4b E 96 0 0 0 E 4b 0 0 0 S 3
C 1 0004 P c7 P 10 E c7 1 0 0 E 10 1 0 0 S 3
C 1 0007 P 69 P d2 E 69 1 1 1 E d2 1 1 1 S 3
C 0 0000 P 33 E 33 1 1 1 S 3
C 0 0003 C 1 0001
P 11 P e2 P 5d P 87 P f0 P 0f
E 11 0 0 1 E e2 0 0 1 E 5d 0 0 1
E 87 0 0 1 E f0 0 0 1 E 0f 0 0 1 S 3
P a9 P 56 P 3b C 2 0000
E a9 0 0 1 S 0 W 28 S 0
C 2 0001 E 56 0 0 1 E 3b 0 0 1 S 3
X

// File: sources.f
uart_line_pkg.sv
uart_reg_pkg.sv
tx_fifo.sv
uart_tx_regs.sv
uart_tx_serializer.sv
uart_tx_top.sv
tb_uart_tx.sv
